/* bus_defines.svh */
// Bus field widths

`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// ===================================================================
// serial field widths of one command
// ===================================================================

// slave select, sent while approval is requested
`define SLAVE_W 2

// address, sent after the slave handshake
`define ADDR_W 12

// data byte, sent beside the address
`define DATA_W 8

// the data line runs as long as the address line
// so DATA_W must not exceed ADDR_W

`endif

/* bus_cmd_pkg.sv */
// Command opcode type

`default_nettype none

package bus_cmd_pkg;

	// ===================================================================
	// user instruction code
	// ===================================================================

	// bit 1 marks a command, bit 0 selects read
	// code 01 is not listed and counts as no command
	typedef enum logic [1:0] {
		OP_NONE  = 2'b00,
		OP_WRITE = 2'b10,
		OP_READ  = 2'b11
	} cmd_op_t;

endpackage

`default_nettype wire

/* bus_fsm_pkg.sv */
// Pipeline stage state types

`default_nettype none

package bus_fsm_pkg;

	// ===================================================================
	// arbitration and slave select stage
	// ===================================================================

	typedef enum logic [2:0] {
		ARB_IDLE,
		ARB_WAIT_FREE,
		ARB_SELECT,
		ARB_WAIT_GRANT,
		ARB_HANDOFF
	} arb_state_t;

	// ===================================================================
	// slave handshake and address/data frame stage
	// ===================================================================

	// finish is the cycle right after the last address bit
	typedef enum logic [2:0] {
		XFER_IDLE,
		XFER_HANDSHAKE,
		XFER_SHIFT,
		XFER_FINISH,
		XFER_READ_WAIT
	} xfer_state_t;

endpackage

`default_nettype wire

/* serial_shifter.sv */
// LSB first serial shifter

`timescale 1ns/1ps
`default_nettype none

module serial_shifter #(
	parameter int WIDTH = 8
)(
	input wire logic clk,
	input wire logic reset,
	input wire logic load,
	input wire logic [WIDTH-1:0] load_word,
	input wire logic shift,
	output logic bit_out,
	output logic last
);

	localparam int CNT_W = $clog2(WIDTH + 1);

	logic [WIDTH-1:0] word_q;
	logic [WIDTH-1:0] word_src;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_src;

	// load together with shift sends bit 0 of the new word at once
	assign word_src = load ? load_word : word_q;
	assign cnt_src = load ? '0 : cnt;

	// zeros fill in from the top once the word is used up
	always_ff @(posedge clk)
	begin
		if (load || shift)
		begin
			word_q <= shift ? (word_src >> 1) : word_src;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt <= '0;
			bit_out <= 1'b0;
			last <= 1'b0;
		end
		else if (shift)
		begin
			bit_out <= word_src[0];
			last <= (cnt_src == CNT_W'(WIDTH - 1));
			// count stops at WIDTH so last fires once per load
			if (cnt_src != CNT_W'(WIDTH))
			begin
				cnt <= cnt_src + 1'b1;
			end
		end
		else
		begin
			bit_out <= 1'b0;
			last <= 1'b0;
			if (load)
			begin
				cnt <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* request_stage.sv */
// Command request register

`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module request_stage (
	input wire logic clk,
	input wire logic reset,
	input wire bus_cmd_pkg::cmd_op_t instruction,
	input wire logic [`SLAVE_W-1:0] slave_select,
	input wire logic [`ADDR_W-1:0] address,
	input wire logic [`DATA_W-1:0] data,
	output logic master_ready,
	output logic req_valid,
	output bus_cmd_pkg::cmd_op_t req_op,
	output logic [`SLAVE_W-1:0] req_slave,
	output logic [`ADDR_W-1:0] req_address,
	output logic [`DATA_W-1:0] req_data,
	input wire logic req_take
);

	logic cmd_valid;
	logic accept;

	// only write and read start a transfer
	assign cmd_valid = (instruction == bus_cmd_pkg::OP_WRITE) ||
		(instruction == bus_cmd_pkg::OP_READ);
	assign accept = master_ready && cmd_valid;

	// one entry, so ready means empty
	assign req_valid = !master_ready;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			master_ready <= 1'b1;
			req_op <= bus_cmd_pkg::OP_NONE;
			req_slave <= '0;
			req_address <= '0;
			req_data <= '0;
		end
		else if (accept)
		begin
			master_ready <= 1'b0;
			req_op <= instruction;
			req_slave <= slave_select;
			req_address <= address;
			req_data <= data;
		end
		else if (req_take)
		begin
			// arbitration keeps its own copy from here on
			master_ready <= 1'b1;
			req_op <= bus_cmd_pkg::OP_NONE;
			req_slave <= '0;
			req_address <= '0;
			req_data <= '0;
		end
	end

endmodule

`default_nettype wire

/* arb_select_stage.sv */
// Bus arbitration and slave select

`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module arb_select_stage (
	input wire logic clk,
	input wire logic reset,
	input wire logic req_valid,
	input wire bus_cmd_pkg::cmd_op_t req_op,
	input wire logic [`SLAVE_W-1:0] req_slave,
	input wire logic [`ADDR_W-1:0] req_address,
	input wire logic [`DATA_W-1:0] req_data,
	output logic req_take,
	input wire logic xfer_ready,
	input wire logic bus_busy,
	input wire logic arbiter_busy,
	input wire logic approval_grant,
	output logic approval_request,
	output logic tx_slave_select,
	output logic hand_valid,
	output bus_cmd_pkg::cmd_op_t hand_op,
	output logic [`ADDR_W-1:0] hand_address,
	output logic [`DATA_W-1:0] hand_data
);

	bus_fsm_pkg::arb_state_t state;

	logic [`SLAVE_W-1:0] slave_q;
	logic [`SLAVE_W-1:0] sel_word;
	logic bus_free;
	logic sel_load;
	logic sel_shift;
	logic sel_last;

	assign bus_free = !bus_busy && !arbiter_busy;

	// start only when the transfer stage can take the grant
	assign req_take = (state == bus_fsm_pkg::ARB_IDLE) && req_valid && xfer_ready && bus_free;

	// a retry sends the whole select again from the held copy
	assign sel_load = req_take || ((state == bus_fsm_pkg::ARB_WAIT_FREE) && bus_free);
	assign sel_word = req_take ? req_slave : slave_q;
	assign sel_shift = sel_load || ((state == bus_fsm_pkg::ARB_SELECT) && !sel_last);

	assign hand_valid = (state == bus_fsm_pkg::ARB_HANDOFF);

	serial_shifter #(
		.WIDTH(`SLAVE_W)
	) select_shifter (
		.clk(clk),
		.reset(reset),
		.load(sel_load),
		.load_word(sel_word),
		.shift(sel_shift),
		.bit_out(tx_slave_select),
		.last(sel_last)
	);

	// command copy held through arbitration
	always_ff @(posedge clk)
	begin
		if (req_take)
		begin
			hand_op <= req_op;
			slave_q <= req_slave;
			hand_address <= req_address;
			hand_data <= req_data;
		end
	end

	// ===================================================================
	// arbitration FSM
	// ===================================================================

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= bus_fsm_pkg::ARB_IDLE;
			approval_request <= 1'b0;
		end
		else
		begin
			case (state)
				bus_fsm_pkg::ARB_IDLE:
				begin
					if (req_take)
					begin
						state <= bus_fsm_pkg::ARB_SELECT;
						approval_request <= 1'b1;
					end
				end
				bus_fsm_pkg::ARB_WAIT_FREE:
				begin
					if (bus_free)
					begin
						state <= bus_fsm_pkg::ARB_SELECT;
						approval_request <= 1'b1;
					end
				end
				bus_fsm_pkg::ARB_SELECT:
				begin
					// request is held for exactly the select bits
					if (sel_last)
					begin
						state <= bus_fsm_pkg::ARB_WAIT_GRANT;
						approval_request <= 1'b0;
					end
				end
				bus_fsm_pkg::ARB_WAIT_GRANT:
				begin
					// grant wins over a busy bus in the same cycle
					if (approval_grant)
					begin
						state <= bus_fsm_pkg::ARB_HANDOFF;
					end
					else if (bus_busy)
					begin
						state <= bus_fsm_pkg::ARB_WAIT_FREE;
					end
				end
				bus_fsm_pkg::ARB_HANDOFF:
				begin
					state <= bus_fsm_pkg::ARB_IDLE;
				end
				default:
				begin
					state <= bus_fsm_pkg::ARB_IDLE;
					approval_request <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* transfer_stage.sv */
// Slave handshake and serial frame

`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module transfer_stage (
	input wire logic clk,
	input wire logic reset,
	input wire logic hand_valid,
	input wire bus_cmd_pkg::cmd_op_t hand_op,
	input wire logic [`ADDR_W-1:0] hand_address,
	input wire logic [`DATA_W-1:0] hand_data,
	output logic xfer_ready,
	input wire logic slave_ready,
	input wire logic rx_done,
	output logic master_valid,
	output logic write_en,
	output logic read_en,
	output logic tx_address,
	output logic tx_data,
	output logic tx_done
);

	bus_fsm_pkg::xfer_state_t state;

	logic is_read;
	logic shift;
	logic addr_last;
	logic [`DATA_W-1:0] data_word;

	assign xfer_ready = (state == bus_fsm_pkg::XFER_IDLE);

	// both lines move together, first bit right after the handshake
	assign shift = ((state == bus_fsm_pkg::XFER_HANDSHAKE) && slave_ready) ||
		((state == bus_fsm_pkg::XFER_SHIFT) && !addr_last);

	// a read keeps the data line at zero
	assign data_word = (hand_op == bus_cmd_pkg::OP_READ) ? '0 : hand_data;

	assign tx_done = addr_last;

	serial_shifter #(
		.WIDTH(`ADDR_W)
	) addr_shifter (
		.clk(clk),
		.reset(reset),
		.load(hand_valid),
		.load_word(hand_address),
		.shift(shift),
		.bit_out(tx_address),
		.last(addr_last)
	);

	// data runs out before the address and then sends zeros
	serial_shifter #(
		.WIDTH(`DATA_W)
	) data_shifter (
		.clk(clk),
		.reset(reset),
		.load(hand_valid),
		.load_word(data_word),
		.shift(shift),
		.bit_out(tx_data),
		.last()
	);

	// ===================================================================
	// transfer FSM
	// ===================================================================

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= bus_fsm_pkg::XFER_IDLE;
			master_valid <= 1'b0;
			write_en <= 1'b0;
			read_en <= 1'b0;
			is_read <= 1'b0;
		end
		else
		begin
			case (state)
				bus_fsm_pkg::XFER_IDLE:
				begin
					if (hand_valid)
					begin
						state <= bus_fsm_pkg::XFER_HANDSHAKE;
						master_valid <= 1'b1;
						write_en <= (hand_op == bus_cmd_pkg::OP_WRITE);
						read_en <= (hand_op == bus_cmd_pkg::OP_READ);
						is_read <= (hand_op == bus_cmd_pkg::OP_READ);
					end
				end
				bus_fsm_pkg::XFER_HANDSHAKE:
				begin
					if (slave_ready)
					begin
						state <= bus_fsm_pkg::XFER_SHIFT;
					end
				end
				bus_fsm_pkg::XFER_SHIFT:
				begin
					// enables stay up until the last address bit is out
					if (addr_last)
					begin
						state <= bus_fsm_pkg::XFER_FINISH;
						master_valid <= 1'b0;
						write_en <= 1'b0;
						read_en <= 1'b0;
					end
				end
				bus_fsm_pkg::XFER_FINISH:
				begin
					if (is_read && !rx_done)
					begin
						state <= bus_fsm_pkg::XFER_READ_WAIT;
					end
					else
					begin
						state <= bus_fsm_pkg::XFER_IDLE;
					end
				end
				bus_fsm_pkg::XFER_READ_WAIT:
				begin
					if (rx_done)
					begin
						state <= bus_fsm_pkg::XFER_IDLE;
					end
				end
				default:
				begin
					state <= bus_fsm_pkg::XFER_IDLE;
					master_valid <= 1'b0;
					write_en <= 1'b0;
					read_en <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* master_out_port.sv */
// Serial bus master output port

`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module master_out_port (
	input wire logic clk,
	input wire logic reset,
	input wire bus_cmd_pkg::cmd_op_t instruction,
	input wire logic [`SLAVE_W-1:0] slave_select,
	input wire logic [`ADDR_W-1:0] address,
	input wire logic [`DATA_W-1:0] data,
	output logic master_ready,
	input wire logic bus_busy,
	input wire logic arbiter_busy,
	input wire logic approval_grant,
	output logic approval_request,
	output logic tx_slave_select,
	input wire logic slave_ready,
	input wire logic rx_done,
	output logic master_valid,
	output logic write_en,
	output logic read_en,
	output logic tx_address,
	output logic tx_data,
	output logic tx_done
);

	// request to arbitration
	wire logic req_valid;
	wire logic req_take;
	wire bus_cmd_pkg::cmd_op_t req_op;
	wire logic [`SLAVE_W-1:0] req_slave;
	wire logic [`ADDR_W-1:0] req_address;
	wire logic [`DATA_W-1:0] req_data;

	// arbitration to transfer
	wire logic xfer_ready;
	wire logic hand_valid;
	wire bus_cmd_pkg::cmd_op_t hand_op;
	wire logic [`ADDR_W-1:0] hand_address;
	wire logic [`DATA_W-1:0] hand_data;

	request_stage request_stage_i (
		.clk(clk),
		.reset(reset),
		.instruction(instruction),
		.slave_select(slave_select),
		.address(address),
		.data(data),
		.master_ready(master_ready),
		.req_valid(req_valid),
		.req_op(req_op),
		.req_slave(req_slave),
		.req_address(req_address),
		.req_data(req_data),
		.req_take(req_take)
	);

	arb_select_stage arb_select_stage_i (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_op(req_op),
		.req_slave(req_slave),
		.req_address(req_address),
		.req_data(req_data),
		.req_take(req_take),
		.xfer_ready(xfer_ready),
		.bus_busy(bus_busy),
		.arbiter_busy(arbiter_busy),
		.approval_grant(approval_grant),
		.approval_request(approval_request),
		.tx_slave_select(tx_slave_select),
		.hand_valid(hand_valid),
		.hand_op(hand_op),
		.hand_address(hand_address),
		.hand_data(hand_data)
	);

	transfer_stage transfer_stage_i (
		.clk(clk),
		.reset(reset),
		.hand_valid(hand_valid),
		.hand_op(hand_op),
		.hand_address(hand_address),
		.hand_data(hand_data),
		.xfer_ready(xfer_ready),
		.slave_ready(slave_ready),
		.rx_done(rx_done),
		.master_valid(master_valid),
		.write_en(write_en),
		.read_en(read_en),
		.tx_address(tx_address),
		.tx_data(tx_data),
		.tx_done(tx_done)
	);

endmodule

`default_nettype wire

/* tb_master_out_port.sv */
// Master output port testbench

`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module tb_master_out_port;

	localparam int MAX_REC = 32;
	localparam int REC_W = 9;

	logic clk;
	logic reset;
	bus_cmd_pkg::cmd_op_t instruction;
	logic [`SLAVE_W-1:0] slave_select;
	logic [`ADDR_W-1:0] address;
	logic [`DATA_W-1:0] data;
	logic master_ready;
	logic bus_busy;
	logic arbiter_busy;
	logic approval_grant;
	logic approval_request;
	logic tx_slave_select;
	logic slave_ready;
	logic rx_done;
	logic master_valid;
	logic write_en;
	logic read_en;
	logic tx_address;
	logic tx_data;
	logic tx_done;

	logic [15:0] stim [0:MAX_REC*REC_W-1];
	int n_rec;
	int accepted;
	int completed;
	bit overlap_seen;
	bit loaded;
	int seed;

	master_out_port master_out_port_i (
		.clk(clk),
		.reset(reset),
		.instruction(instruction),
		.slave_select(slave_select),
		.address(address),
		.data(data),
		.master_ready(master_ready),
		.bus_busy(bus_busy),
		.arbiter_busy(arbiter_busy),
		.approval_grant(approval_grant),
		.approval_request(approval_request),
		.tx_slave_select(tx_slave_select),
		.slave_ready(slave_ready),
		.rx_done(rx_done),
		.master_valid(master_valid),
		.write_en(write_en),
		.read_en(read_en),
		.tx_address(tx_address),
		.tx_data(tx_data),
		.tx_done(tx_done)
	);

	always #5 clk = ~clk;

	// record fields op slave addr data busy retry grant ready rx
	function automatic logic [15:0] field(input int rec, input int idx);
		return stim[rec*REC_W + idx];
	endfunction

	task automatic fail_now(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("test failed");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check_op(input bus_cmd_pkg::cmd_op_t exp, input bus_cmd_pkg::cmd_op_t got);
		if (got !== exp)
		begin
			fail_now($sformatf("opcode expected %b got %b", exp, got));
		end
	endtask

	task automatic check_select(input logic [`SLAVE_W-1:0] exp, input logic [`SLAVE_W-1:0] got);
		if (got !== exp)
		begin
			fail_now($sformatf("slave select expected %h got %h", exp, got));
		end
	endtask

	task automatic check_frame(input logic [`ADDR_W-1:0] exp_addr, input logic [`DATA_W-1:0] exp_data,
		input logic [`ADDR_W-1:0] got_addr, input logic [`DATA_W-1:0] got_data);
		if (got_addr !== exp_addr || got_data !== exp_data)
		begin
			fail_now($sformatf("frame expected %h/%h got %h/%h",
				exp_addr, exp_data, got_addr, got_data));
		end
	endtask

	// serial select bits while approval_request is high
	task automatic collect_select(output logic [`SLAVE_W-1:0] bits);
		@(negedge clk);
		while (!approval_request)
		begin
			@(negedge clk);
		end
		bits[0] = tx_slave_select;
		for (int i = 1; i < `SLAVE_W; i++)
		begin
			@(negedge clk);
			if (!approval_request)
			begin
				fail_now("approval_request dropped during select");
			end
			bits[i] = tx_slave_select;
		end
		@(negedge clk);
		if (approval_request)
		begin
			fail_now("approval_request held past the select bits");
		end
	endtask

	// ===================================================================
	// command driver
	// ===================================================================

	task automatic drive_commands();
		for (int k = 0; k < n_rec; k++)
		begin
			if (k >= 2)
			begin
				repeat ($random(seed) & 32'h3) @(posedge clk);
			end
			@(posedge clk);
			#1;
			while (!master_ready)
			begin
				@(posedge clk);
				#1;
			end
			instruction = bus_cmd_pkg::cmd_op_t'(2'(field(k, 0)));
			slave_select = `SLAVE_W'(field(k, 1));
			address = `ADDR_W'(field(k, 2));
			data = `DATA_W'(field(k, 3));
			@(posedge clk);
			#1;
			instruction = bus_cmd_pkg::OP_NONE;
			if (accepted - completed >= 2)
			begin
				fail_now("a third command was accepted while two were in flight");
			end
			if (completed < k)
			begin
				overlap_seen = 1'b1;
			end
			accepted++;
		end
	endtask

	// ===================================================================
	// arbiter model
	// ===================================================================

	task automatic run_arbiter();
		logic [`SLAVE_W-1:0] sel;
		int busy_n;
		for (int k = 0; k < n_rec; k++)
		begin
			wait (accepted > k);
			busy_n = field(k, 4);
			if (busy_n > 0)
			begin
				// even records block with the bus, odd ones with the arbiter
				bus_busy = (k % 2 == 0);
				arbiter_busy = (k % 2 == 1);
				repeat (busy_n)
				begin
					@(negedge clk);
					if (approval_request)
					begin
						fail_now("approval_request high while busy");
					end
					@(posedge clk);
					#1;
				end
				bus_busy = 1'b0;
				arbiter_busy = 1'b0;
			end
			collect_select(sel);
			check_select(`SLAVE_W'(field(k, 1)), sel);
			if (field(k, 5) != 0)
			begin
				@(posedge clk);
				#1;
				bus_busy = 1'b1;
				repeat (2)
				begin
					@(negedge clk);
					if (approval_request)
					begin
						fail_now("approval_request high while bus busy on retry");
					end
					@(posedge clk);
					#1;
				end
				bus_busy = 1'b0;
				collect_select(sel);
				check_select(`SLAVE_W'(field(k, 1)), sel);
			end
			repeat (field(k, 6) + ($random(seed) & 32'h1)) @(posedge clk);
			@(posedge clk);
			#1;
			approval_grant = 1'b1;
			@(posedge clk);
			#1;
			approval_grant = 1'b0;
		end
	endtask

	// ===================================================================
	// slave and receiver model
	// ===================================================================

	task automatic run_slave();
		logic [`ADDR_W-1:0] got_addr;
		logic [`ADDR_W-1:0] got_line;
		logic [`DATA_W-1:0] exp_data;
		bus_cmd_pkg::cmd_op_t exp_op;
		bus_cmd_pkg::cmd_op_t got_op;
		for (int k = 0; k < n_rec; k++)
		begin
			exp_op = bus_cmd_pkg::cmd_op_t'(2'(field(k, 0)));
			exp_data = (exp_op == bus_cmd_pkg::OP_READ) ? '0 : `DATA_W'(field(k, 3));
			@(negedge clk);
			while (!master_valid)
			begin
				@(negedge clk);
			end
			got_op = write_en ? bus_cmd_pkg::OP_WRITE :
				(read_en ? bus_cmd_pkg::OP_READ : bus_cmd_pkg::OP_NONE);
			check_op(exp_op, got_op);
			repeat (field(k, 7))
			begin
				@(negedge clk);
				if (!master_valid || tx_done || tx_address !== 1'b0 || tx_data !== 1'b0)
				begin
					fail_now("frame moved before slave_ready");
				end
			end
			@(posedge clk);
			#1;
			slave_ready = 1'b1;
			@(posedge clk);
			#1;
			slave_ready = 1'b0;
			for (int i = 0; i < `ADDR_W; i++)
			begin
				@(negedge clk);
				got_addr[i] = tx_address;
				got_line[i] = tx_data;
				if (tx_done !== (i == `ADDR_W - 1))
				begin
					fail_now($sformatf("tx_done wrong on address bit %0d", i));
				end
				if (!master_valid || write_en !== (exp_op == bus_cmd_pkg::OP_WRITE) ||
					read_en !== (exp_op == bus_cmd_pkg::OP_READ))
				begin
					fail_now("enables not held through the frame");
				end
			end
			if (got_line[`ADDR_W-1:`DATA_W] != 0)
			begin
				fail_now("tx_data not zero past the data byte");
			end
			check_frame(`ADDR_W'(field(k, 2)), exp_data, got_addr, got_line[`DATA_W-1:0]);
			@(negedge clk);
			if (master_valid || write_en || read_en || tx_done)
			begin
				fail_now("master_valid, enables or tx_done still high after the frame");
			end
			if (exp_op == bus_cmd_pkg::OP_READ)
			begin
				repeat (field(k, 8)) @(posedge clk);
				@(posedge clk);
				#1;
				rx_done = 1'b1;
				completed++;
				@(posedge clk);
				#1;
				rx_done = 1'b0;
			end
			else
			begin
				completed++;
			end
		end
	endtask

	initial
	begin
		wait (loaded);
		#(n_rec * 200 * 10);
		$display("simulation hung: watchdog ran out before all commands finished");
		$display("test failed");
		$fatal(1, "watchdog timeout");
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		instruction = bus_cmd_pkg::OP_NONE;
		slave_select = '0;
		address = '0;
		data = '0;
		bus_busy = 1'b0;
		arbiter_busy = 1'b0;
		approval_grant = 1'b0;
		slave_ready = 1'b0;
		rx_done = 1'b0;
		accepted = 0;
		completed = 0;
		overlap_seen = 1'b0;
		seed = 32'h95f636d5;
		for (int i = 0; i < MAX_REC * REC_W; i++)
		begin
			stim[i] = 16'hffff;
		end
		$readmemh("master_out_input.txt", stim);
		n_rec = 0;
		while (n_rec < MAX_REC && field(n_rec, 0) != 16'hffff)
		begin
			n_rec++;
		end
		loaded = 1'b1;
		if (n_rec == 0)
		begin
			fail_now("no records in the input file");
		end
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		if (master_ready !== 1'b1 || approval_request || master_valid || write_en ||
			read_en || tx_done || tx_slave_select || tx_address || tx_data)
		begin
			fail_now("outputs wrong after reset");
		end
		fork
			drive_commands();
			run_arbiter();
			run_slave();
		join
		if (!overlap_seen)
		begin
			fail_now("no command was accepted while another was transferring");
		end
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* master_out_input.txt */
// op slave addr data busy retry grant_dly ready_dly rx_dly (all hex)
// op 2 is write, 3 is read; delays count clock cycles
2 1 5a3 c4 0 0 1 0 0
2 2 0f1 3b 0 0 0 2 0
3 3 abc 77 2 0 1 1 3
2 0 123 e5 0 1 2 0 0
3 1 fff 01 3 1 0 4 0
2 3 800 80 1 0 3 1 0
3 2 001 ff 0 0 0 0 5
2 1 7ee 5a 0 1 1 3 0
3 0 456 a5 1 1 2 2 2

/* flist.f */
+incdir+.
bus_cmd_pkg.sv
bus_fsm_pkg.sv
serial_shifter.sv
request_stage.sv
arb_select_stage.sv
transfer_stage.sv
master_out_port.sv
tb_master_out_port.sv

/* Makefile */
TOP ?= tb_master_out_port
DUT_TOP ?= master_out_port
VERILATOR ?= verilator
LOG ?= sim.log
FLIST ?= flist.f
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -q "^test passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
